// ==== hdl/apb_gpio.sv ====
// GPIO register block
// OUT and DIR registers, two-flop input synchroniser, read mux
`include "chip_config.svh"

module apb_gpio (
  input  logic                i_clk,
  input  logic                i_sys_rst,
  input  chip_pkg::gpio_vec_t i_pad_in,
  output chip_pkg::gpio_vec_t o_pad_out,
  output chip_pkg::gpio_vec_t o_pad_dir,
  apb_if.slave                bus
);
  import chip_pkg::*;

  localparam bus_addr_t OFS_IN = `CHIP_GPIO_IN;
  localparam bus_addr_t OFS_OUT = `CHIP_GPIO_OUT;
  localparam bus_addr_t OFS_DIR = `CHIP_GPIO_DIR;

  gpio_vec_t in_meta;
  gpio_vec_t in_sync;
  logic      bus_wr;

  assign bus_wr = bus.psel && bus.penable && bus.pwrite;

  // Writes land at the end of the access cycle
  always_ff @(posedge i_clk) begin
    if (i_sys_rst) begin
      o_pad_out <= '0;
      o_pad_dir <= '0;
    end else if (bus_wr) begin
      if (bus.paddr[3:2] == OFS_OUT[3:2]) begin
        o_pad_out <= bus.pwdata[`CHIP_GPIO_WIDTH-1:0];
      end
      if (bus.paddr[3:2] == OFS_DIR[3:2]) begin
        o_pad_dir <= bus.pwdata[`CHIP_GPIO_WIDTH-1:0];
      end
    end
  end

  // Pads are asynchronous to the clock
  always_ff @(posedge i_clk) begin
    in_meta <= i_pad_in;
    in_sync <= in_meta;
  end

  always_comb begin
    if (bus.paddr[3:2] == OFS_IN[3:2]) begin
      bus.prdata = bus_data_t'(in_sync);
    end else if (bus.paddr[3:2] == OFS_OUT[3:2]) begin
      bus.prdata = bus_data_t'(o_pad_out);
    end else if (bus.paddr[3:2] == OFS_DIR[3:2]) begin
      bus.prdata = bus_data_t'(o_pad_dir);
    end else begin
      bus.prdata = '0;
    end
  end

endmodule

// ==== hdl/apb_if.sv ====
// APB-style register bus without pready
// Master and slave modports

interface apb_if;
  import chip_pkg::*;

  logic      psel;
  logic      penable;
  logic      pwrite;
  bus_addr_t paddr;
  bus_data_t pwdata;
  bus_data_t prdata;

  modport master (
    output psel,
    output penable,
    output pwrite,
    output paddr,
    output pwdata,
    input  prdata
  );

  modport slave (
    input  psel,
    input  penable,
    input  pwrite,
    input  paddr,
    input  pwdata,
    output prdata
  );

endinterface

// ==== hdl/apb_prci.sv ====
// Reset and clock control
// Lock synchroniser, reset sequencer FSM, soft reset, status registers
`include "chip_config.svh"

module apb_prci (
  input  logic i_clk,
  input  logic i_reset,
  input  logic i_pll_locked,
  output logic o_sys_rst,
  apb_if.slave bus
);
  import chip_pkg::*;

  localparam int HOLD_W = $clog2(`CHIP_RST_HOLD_CYCLES + 1);
  localparam int HOLD_LAST = `CHIP_RST_HOLD_CYCLES - 1;
  localparam bus_addr_t OFS_STATUS = `CHIP_PRCI_STATUS;
  localparam bus_addr_t OFS_CTRL = `CHIP_PRCI_CTRL;

  prci_state_e       state;
  logic [HOLD_W-1:0] hold_cnt;
  reset_count_t      reset_count;
  logic              lock_meta;
  logic              lock_sync;
  logic              bus_wr;
  logic              soft_req;
  bus_data_t         status;

  // Two-flop synchroniser for the PLL lock
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      lock_meta <= 1'b0;
      lock_sync <= 1'b0;
    end else begin
      lock_meta <= i_pll_locked;
      lock_sync <= lock_meta;
    end
  end

  assign bus_wr = bus.psel && bus.penable && bus.pwrite;
  assign soft_req = bus_wr && (bus.paddr[3:2] == OFS_CTRL[3:2]) && bus.pwdata[0];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state       <= PRCI_POWER_ON;
      hold_cnt    <= '0;
      reset_count <= '0;
    end else begin
      unique case (state)
        PRCI_POWER_ON: begin
          state <= PRCI_WAIT_LOCK;
        end
        PRCI_WAIT_LOCK: begin
          if (lock_sync) begin
            state    <= PRCI_HOLD;
            hold_cnt <= '0;
          end
        end
        PRCI_HOLD: begin
          if (!lock_sync) begin
            state <= PRCI_WAIT_LOCK;
          end else if (soft_req) begin
            // Start the hold time again
            hold_cnt <= '0;
          end else if (hold_cnt == HOLD_W'(HOLD_LAST)) begin
            state       <= PRCI_RUN;
            reset_count <= reset_count + 1'b1;
          end else begin
            hold_cnt <= hold_cnt + 1'b1;
          end
        end
        PRCI_RUN: begin
          // Lock loss wins over a soft reset
          if (!lock_sync) begin
            state <= PRCI_WAIT_LOCK;
          end else if (soft_req) begin
            state    <= PRCI_HOLD;
            hold_cnt <= '0;
          end
        end
      endcase
    end
  end

  assign o_sys_rst = (state != PRCI_RUN);

  assign status = {16'h0000, reset_count, 6'b000000, o_sys_rst, lock_sync};

  // CTRL reads back as zero
  always_comb begin
    if (bus.paddr[3:2] == OFS_STATUS[3:2]) begin
      bus.prdata = status;
    end else begin
      bus.prdata = '0;
    end
  end

endmodule

// ==== hdl/chip_pkg.sv ====
// Shared types of the chip subsystem
// Bus address and data, GPIO vector, reset counter, PRCI states
`include "chip_config.svh"

package chip_pkg;

  // Byte address on the host and APB side
  typedef logic [11:0] bus_addr_t;

  // Register data
  typedef logic [31:0] bus_data_t;

  // One bit per pad
  typedef logic [`CHIP_GPIO_WIDTH-1:0] gpio_vec_t;

  // Number of completed reset sequences
  typedef logic [7:0] reset_count_t;

  // Reset sequencer states
  typedef enum logic [1:0] {
    PRCI_POWER_ON,
    PRCI_WAIT_LOCK,
    PRCI_HOLD,
    PRCI_RUN
  } prci_state_e;

endpackage

// ==== hdl/chip_top.sv ====
// Chip subsystem top level
// GPIO pad tristates, host bridge, PRCI and GPIO instances
`include "chip_config.svh"

module chip_top (
  input  logic                        i_clk,
  input  logic                        i_reset,
  input  logic                        i_pll_locked,
  // Pads: [11:4] LEDs, [3:0] switches
  inout  wire [`CHIP_GPIO_WIDTH-1:0]  io_gpio,
  // Host strobe port
  input  logic                        i_host_req,
  input  logic                        i_host_write,
  input  chip_pkg::bus_addr_t         i_host_addr,
  input  chip_pkg::bus_data_t         i_host_wdata,
  output logic                        o_host_ack,
  output chip_pkg::bus_data_t         o_host_rdata,
  output logic                        o_host_err
);
  import chip_pkg::*;

  logic      w_sys_rst;
  gpio_vec_t w_gpio_out;
  gpio_vec_t w_gpio_dir;
  gpio_vec_t w_gpio_in;

  apb_if prci_bus ();
  apb_if gpio_bus ();

  // Pad drives its out bit only when its direction bit is set
  genvar i;
  generate
    for (i = 0; i < `CHIP_GPIO_WIDTH; i++) begin : g_pad
      assign io_gpio[i] = w_gpio_dir[i] ? w_gpio_out[i] : 1'bz;
    end
  endgenerate

  assign w_gpio_in = io_gpio;

  host_apb_bridge bridge0 (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_req    (i_host_req),
    .i_write  (i_host_write),
    .i_addr   (i_host_addr),
    .i_wdata  (i_host_wdata),
    .o_ack    (o_host_ack),
    .o_rdata  (o_host_rdata),
    .o_err    (o_host_err),
    .prci_bus (prci_bus.master),
    .gpio_bus (gpio_bus.master)
  );

  // Reset and clock control, held by the power-on reset only
  apb_prci prci0 (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_pll_locked (i_pll_locked),
    .o_sys_rst    (w_sys_rst),
    .bus          (prci_bus.slave)
  );

  // GPIO is cleared by the system reset from the sequencer
  apb_gpio gpio0 (
    .i_clk     (i_clk),
    .i_sys_rst (w_sys_rst),
    .i_pad_in  (w_gpio_in),
    .o_pad_out (w_gpio_out),
    .o_pad_dir (w_gpio_dir),
    .bus       (gpio_bus.slave)
  );

endmodule

// ==== hdl/host_apb_bridge.sv ====
// Host strobe to APB-style bridge
// Setup/access/respond sequencer, target decode and acknowledge
`include "chip_config.svh"

module host_apb_bridge (
  input  logic                i_clk,
  input  logic                i_reset,
  input  logic                i_req,
  input  logic                i_write,
  input  chip_pkg::bus_addr_t i_addr,
  input  chip_pkg::bus_data_t i_wdata,
  output logic                o_ack,
  output chip_pkg::bus_data_t o_rdata,
  output logic                o_err,
  apb_if.master               prci_bus,
  apb_if.master               gpio_bus
);
  import chip_pkg::*;

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_SETUP,
    PH_ACCESS,
    PH_RESPOND
  } phase_e;

  typedef enum logic [1:0] {
    TGT_NONE,
    TGT_PRCI,
    TGT_GPIO
  } target_e;

  localparam bus_addr_t PRCI_BASE = `CHIP_PRCI_BASE;
  localparam bus_addr_t GPIO_BASE = `CHIP_GPIO_BASE;

  phase_e    phase;
  target_e   target;
  target_e   target_dec;
  logic      req_write;
  bus_addr_t req_addr;
  bus_data_t req_wdata;
  logic      bus_active;
  bus_data_t sel_rdata;

  // Decode once, on the incoming request
  always_comb begin
    if (i_addr[11:8] == PRCI_BASE[11:8]) begin
      target_dec = TGT_PRCI;
    end else if (i_addr[11:8] == GPIO_BASE[11:8]) begin
      target_dec = TGT_GPIO;
    end else begin
      target_dec = TGT_NONE;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      phase  <= PH_IDLE;
      target <= TGT_NONE;
      o_err  <= 1'b0;
    end else begin
      unique case (phase)
        PH_IDLE: begin
          // Requests are only taken when idle
          if (i_req) begin
            phase  <= PH_SETUP;
            target <= target_dec;
          end
        end
        PH_SETUP: begin
          phase <= PH_ACCESS;
        end
        PH_ACCESS: begin
          phase <= PH_RESPOND;
          o_err <= (target == TGT_NONE);
        end
        PH_RESPOND: begin
          phase <= PH_IDLE;
          o_err <= 1'b0;
        end
      endcase
    end
  end

  // Request payload and response data
  always_ff @(posedge i_clk) begin
    if (phase == PH_IDLE && i_req) begin
      req_write <= i_write;
      req_addr  <= i_addr;
      req_wdata <= i_wdata;
    end
    if (phase == PH_ACCESS) begin
      o_rdata <= req_write ? '0 : sel_rdata;
    end
  end

  always_comb begin
    unique case (target)
      TGT_PRCI: sel_rdata = prci_bus.prdata;
      TGT_GPIO: sel_rdata = gpio_bus.prdata;
      default:  sel_rdata = '0;
    endcase
  end

  assign o_ack      = (phase == PH_RESPOND);
  assign bus_active = (phase == PH_SETUP) || (phase == PH_ACCESS);

  // Only the selected bus sees psel and penable
  assign prci_bus.psel    = bus_active && (target == TGT_PRCI);
  assign prci_bus.penable = (phase == PH_ACCESS) && (target == TGT_PRCI);
  assign prci_bus.pwrite  = req_write;
  assign prci_bus.paddr   = req_addr;
  assign prci_bus.pwdata  = req_wdata;

  assign gpio_bus.psel    = bus_active && (target == TGT_GPIO);
  assign gpio_bus.penable = (phase == PH_ACCESS) && (target == TGT_GPIO);
  assign gpio_bus.pwrite  = req_write;
  assign gpio_bus.paddr   = req_addr;
  assign gpio_bus.pwdata  = req_wdata;

endmodule

// ==== include/chip_config.svh ====
// Chip subsystem configuration macros
// GPIO width, reset hold time, address map and register offsets
`ifndef CHIP_CONFIG_SVH
`define CHIP_CONFIG_SVH

// Pads: [11:4] outputs to LEDs, [3:0] switch inputs
`define CHIP_GPIO_WIDTH 12

// Cycles of system reset after the synchronised lock is seen
`define CHIP_RST_HOLD_CYCLES 16

// Address map, target selected by address bits 11:8
`define CHIP_PRCI_BASE 12'h000
`define CHIP_GPIO_BASE 12'h100

// Register offsets, decoded on address bits 3:2
`define CHIP_PRCI_STATUS 12'h000
`define CHIP_PRCI_CTRL   12'h004
`define CHIP_GPIO_IN     12'h000
`define CHIP_GPIO_OUT    12'h004
`define CHIP_GPIO_DIR    12'h008

`endif

// ==== sim/tb_chip_top.sv ====
// Testbench for the chip subsystem top level
// Clock, reset, switch model, host tasks, tests, assertions and watchdog
`include "chip_config.svh"

module tb_chip_top;
  timeunit 1ns;
  timeprecision 100ps;
  import chip_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DELAY = 10;
  // Rough length of all tests in clock cycles
  localparam int TEST_CYCLES = 250;
  localparam int RUN_LIMIT = 2 + `CHIP_RST_HOLD_CYCLES + 10;
  localparam bus_addr_t A_STATUS = `CHIP_PRCI_BASE + `CHIP_PRCI_STATUS;
  localparam bus_addr_t A_CTRL = `CHIP_PRCI_BASE + `CHIP_PRCI_CTRL;
  localparam bus_addr_t A_IN = `CHIP_GPIO_BASE + `CHIP_GPIO_IN;
  localparam bus_addr_t A_OUT = `CHIP_GPIO_BASE + `CHIP_GPIO_OUT;
  localparam bus_addr_t A_DIR = `CHIP_GPIO_BASE + `CHIP_GPIO_DIR;
  localparam bus_addr_t A_UNMAPPED = 12'h200;
  localparam gpio_vec_t SW_MASK = gpio_vec_t'(4'hF);

  logic      i_clk;
  logic      i_reset;
  logic      i_pll_locked;
  logic      i_host_req;
  logic      i_host_write;
  bus_addr_t i_host_addr;
  bus_data_t i_host_wdata;
  logic      o_host_ack;
  bus_data_t o_host_rdata;
  logic      o_host_err;
  wire [`CHIP_GPIO_WIDTH-1:0] io_gpio;

  logic        sw_enable;
  logic [3:0]  sw_value;
  gpio_vec_t   model_out;
  gpio_vec_t   model_dir;
  int          data_errors = 0;
  int          delay_errors = 0;
  int          width_errors = 0;
  int unsigned cycle_count = 0;

  chip_top i_dut (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_pll_locked (i_pll_locked),
    .io_gpio      (io_gpio),
    .i_host_req   (i_host_req),
    .i_host_write (i_host_write),
    .i_host_addr  (i_host_addr),
    .i_host_wdata (i_host_wdata),
    .o_host_ack   (o_host_ack),
    .o_host_rdata (o_host_rdata),
    .o_host_err   (o_host_err)
  );

  // Switches on pads 3:0, weak pull-downs on every pad
  assign io_gpio[3:0] = sw_enable ? sw_value : 4'bz;

  genvar g;
  generate
    for (g = 0; g < `CHIP_GPIO_WIDTH; g++) begin : g_pull
      pulldown (io_gpio[g]);
    end
  endgenerate

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
  end

  // Bridge handshake timing
  ack_delay: assert property (@(posedge i_clk) disable iff (i_reset)
    i_host_req |-> ##3 o_host_ack)
  else begin
    delay_errors++;
    $display("ERR %0t o_host_ack expected 1 got 0 three cycles after i_host_req", $time);
  end

  ack_width: assert property (@(posedge i_clk) disable iff (i_reset)
    o_host_ack |=> !o_host_ack)
  else begin
    width_errors++;
    $display("ERR %0t o_host_ack expected 0 got 1 in the cycle after the ack", $time);
  end

  initial begin
    #(20 * TEST_CYCLES * CLK_PERIOD);
    $display("Watchdog expired, the tests did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge i_clk);
    #DRIVE_DELAY;
  endtask

  task automatic check_value(input string name, input bus_data_t expected,
                             input bus_data_t actual);
    assert (actual === expected) else begin
      data_errors++;
      $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  // One strobe, then wait for the acknowledge and one idle cycle
  task automatic host_access(input logic write, input bus_addr_t addr, input bus_data_t wdata,
                             input logic exp_err, output bus_data_t rdata);
    int waited;
    waited = 0;
    rdata = '0;
    i_host_req = 1'b1;
    i_host_write = write;
    i_host_addr = addr;
    i_host_wdata = wdata;
    wait_cycles(1);
    i_host_req = 1'b0;
    while (!o_host_ack && waited < 8) begin
      wait_cycles(1);
      waited++;
    end
    if (!o_host_ack) begin
      data_errors++;
      $display("No acknowledge from the bridge for address %h", addr);
    end else begin
      check_value("o_host_err", bus_data_t'(exp_err), bus_data_t'(o_host_err));
      rdata = o_host_rdata;
    end
    wait_cycles(1);
  endtask

  task automatic host_write(input bus_addr_t addr, input bus_data_t data);
    bus_data_t unused;
    host_access(1'b1, addr, data, 1'b0, unused);
  endtask

  task automatic read_check(input bus_addr_t addr, input bus_data_t expected,
                            input string name);
    bus_data_t rdata;
    host_access(1'b0, addr, '0, 1'b0, rdata);
    check_value(name, expected, rdata);
  endtask

  function automatic bus_data_t status_word(input int count, input logic rst, input logic lock);
    return {16'h0000, 8'(count), 6'b000000, rst, lock};
  endfunction

  // Undriven pads read 0 through the pull-down
  function automatic gpio_vec_t pad_model();
    return (model_out & model_dir & ~SW_MASK) |
           (sw_enable ? gpio_vec_t'(sw_value) : gpio_vec_t'(0));
  endfunction

  task automatic check_pads();
    gpio_vec_t expected;
    expected = pad_model();
    check_value("io_gpio[11:4]", bus_data_t'(expected[`CHIP_GPIO_WIDTH-1:4]),
                bus_data_t'(io_gpio[`CHIP_GPIO_WIDTH-1:4]));
  endtask

  // Poll STATUS until the reset bit reaches the wanted value
  task automatic poll_reset(input logic want_rst, output bus_data_t status);
    int unsigned start;
    start = cycle_count;
    do begin
      host_access(1'b0, A_STATUS, '0, 1'b0, status);
    end while (status[1] !== want_rst && cycle_count - start <= RUN_LIMIT);
    if (status[1] !== want_rst) begin
      data_errors++;
      $display("System reset did not go to %0b within %0d cycles", want_rst, RUN_LIMIT);
    end
  endtask

  task automatic drive_random_gpio();
    model_out = gpio_vec_t'($urandom);
    model_dir = gpio_vec_t'($urandom) & ~SW_MASK;
    host_write(A_OUT, bus_data_t'(model_out));
    host_write(A_DIR, bus_data_t'(model_dir));
    read_check(A_OUT, bus_data_t'(model_out), "GPIO_OUT");
    read_check(A_DIR, bus_data_t'(model_dir), "GPIO_DIR");
    check_pads();
  endtask

  initial begin
    bus_data_t status;
    void'($urandom(80360));
    i_reset = 1'b1;
    i_pll_locked = 1'b0;
    i_host_req = 1'b0;
    i_host_write = 1'b0;
    i_host_addr = '0;
    i_host_wdata = '0;
    sw_enable = 1'b0;
    sw_value = 4'h0;
    model_out = '0;
    model_dir = '0;
    wait_cycles(4);
    i_reset = 1'b0;
    wait_cycles(2);

    // Reset with lock low
    read_check(A_STATUS, status_word(0, 1'b1, 1'b0), "PRCI_STATUS");
    check_pads();

    // Lock rises and the first reset sequence completes
    i_pll_locked = 1'b1;
    poll_reset(1'b0, status);
    check_value("PRCI_STATUS", status_word(1, 1'b0, 1'b1), status);

    repeat (3) drive_random_gpio();

    // Open switches read as the pull-down
    read_check(A_IN, bus_data_t'(pad_model()), "GPIO_IN");
    sw_enable = 1'b1;

    // Switch inputs through the synchroniser
    repeat (4) begin
      sw_value = 4'($urandom);
      wait_cycles(2);
      read_check(A_IN, bus_data_t'(pad_model()), "GPIO_IN");
    end

    // Soft reset clears the GPIO registers while in HOLD
    host_write(A_CTRL, 32'h0000_0001);
    read_check(A_STATUS, status_word(1, 1'b1, 1'b1), "PRCI_STATUS");
    model_out = '0;
    model_dir = '0;
    read_check(A_OUT, '0, "GPIO_OUT");
    read_check(A_DIR, '0, "GPIO_DIR");
    check_pads();
    poll_reset(1'b0, status);
    check_value("PRCI_STATUS", status_word(2, 1'b0, 1'b1), status);

    // Lock loss in RUN, then relock
    i_pll_locked = 1'b0;
    poll_reset(1'b1, status);
    check_value("PRCI_STATUS", status_word(2, 1'b1, 1'b0), status);
    i_pll_locked = 1'b1;
    poll_reset(1'b0, status);
    check_value("PRCI_STATUS", status_word(3, 1'b0, 1'b1), status);

    // Unmapped target leaves the GPIO registers alone
    drive_random_gpio();
    host_access(1'b0, A_UNMAPPED, '0, 1'b1, status);
    check_value("o_host_rdata", '0, status);
    host_access(1'b1, A_UNMAPPED, 32'hFFFF_FFFF, 1'b1, status);
    check_value("o_host_rdata", '0, status);
    // Writable offsets behind the unmapped base
    host_access(1'b1, A_UNMAPPED + `CHIP_GPIO_OUT, 32'hFFFF_FFFF, 1'b1, status);
    check_value("o_host_rdata", '0, status);
    host_access(1'b1, A_UNMAPPED + `CHIP_GPIO_DIR, 32'hFFFF_FFFF, 1'b1, status);
    check_value("o_host_rdata", '0, status);
    read_check(A_OUT, bus_data_t'(model_out), "GPIO_OUT");
    read_check(A_DIR, bus_data_t'(model_dir), "GPIO_DIR");
    check_pads();

    $display("Errors: %0d data, %0d ack delay, %0d ack width",
             data_errors, delay_errors, width_errors);
    if (data_errors + delay_errors + width_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+include
hdl/chip_pkg.sv
hdl/apb_if.sv
hdl/host_apb_bridge.sv
hdl/apb_prci.sv
hdl/apb_gpio.sv
hdl/chip_top.sv
sim/tb_chip_top.sv
